//--- core_pipe.f
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/fetch_stage.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/core_pipeline.sv
dv/tb_memory.sv
dv/tb_core_pipeline.sv

//--- dv/tb_core_pipeline.sv
`timescale 1ns/1ps

module tb_core_pipeline;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] mask;
	} store_t;

	localparam logic [3:0]  N_STORES  = 4'd9;
	localparam int          TIMEOUT   = 2000;
	localparam logic [31:0] BASE      = 32'h200;
	localparam logic [31:0] LOAD_WORD = 32'h1234_5678;
	localparam logic [31:0] FULL      = 32'hffff_ffff;
	localparam logic [6:0]  OPC_IMM   = 7'b001_0011;
	localparam logic [6:0]  OPC_LOAD  = 7'b000_0011;
	localparam logic [6:0]  OPC_JALR  = 7'b110_0111;
	localparam logic [2:0]  SB        = 3'b000;
	localparam logic [2:0]  SW        = 3'b010;

	logic        clk;
	logic        arst_n;
	logic [31:0] memory_i_addr;
	logic [31:0] memory_inst;
	logic [31:0] memory_d_addr;
	logic [31:0] memory_rdata;
	logic        memory_wen;
	logic [31:0] memory_wmask;
	logic [31:0] memory_wdata;
	logic        memory_ready;
	logic        commit;
	logic [3:0]  store_idx;
	store_t      exp_store [16];
	store_t      exp_now;
	string       exp_name [16];

	core_pipeline i_dut (.*);
	tb_memory i_mem (.*);

	// ############################################################
	// instruction encoders
	// ############################################################
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b011_0011};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b010_0011};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b110_0011};
	endfunction

	function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'b011_0111};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b110_1111};
	endfunction

	task automatic put_word(input logic [31:0] addr, input logic [31:0] word);
		i_mem.mem[addr[11:2]] <= word;
	endtask

	task automatic expect_store(input logic [3:0] idx, input string name,
		input logic [31:0] addr, input logic [31:0] data, input logic [31:0] mask);
		exp_store[idx] = '{addr, data, mask};
		exp_name[idx]  = name;
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	assign commit  = memory_wen && memory_ready;
	assign exp_now = exp_store[store_idx];

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			store_idx <= 4'd0;
		end else if (commit) begin
			store_idx <= store_idx + 4'd1; // committed stores so far.
		end
	end

	// ############################################################
	// checks
	// ############################################################
	a_reset_quiet: assert property (@(posedge clk) (!arst_n || !$past(arst_n))
		|-> (!memory_wen && memory_i_addr == 32'h0))
		else report_failure("store or nonzero fetch address during or right after reset");

	a_store_addr: assert property (@(posedge clk) disable iff (!arst_n)
		(commit && store_idx < N_STORES) |-> memory_d_addr == exp_now.addr)
		else report_failure($sformatf("error %s: expected addr %h, actual %h",
			exp_name[$sampled(store_idx)], $sampled(exp_now.addr), $sampled(memory_d_addr)));

	a_store_mask: assert property (@(posedge clk) disable iff (!arst_n)
		(commit && store_idx < N_STORES) |-> memory_wmask == exp_now.mask)
		else report_failure($sformatf("error %s: expected mask %h, actual %h",
			exp_name[$sampled(store_idx)], $sampled(exp_now.mask), $sampled(memory_wmask)));

	a_store_data: assert property (@(posedge clk) disable iff (!arst_n)
		(commit && store_idx < N_STORES)
		|-> (memory_wdata & memory_wmask) == (exp_now.data & exp_now.mask))
		else report_failure($sformatf("error %s: expected data %h, actual %h",
			exp_name[$sampled(store_idx)], $sampled(exp_now.data & exp_now.mask),
			$sampled(memory_wdata & memory_wmask)));

	a_store_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(memory_wen && !memory_ready) |=> (memory_wen && $stable(memory_d_addr)
		&& $stable(memory_wdata) && $stable(memory_wmask)))
		else report_failure("store request changed while the memory was not ready");

	// ############################################################
	// program, expected stores and run
	// ############################################################
	initial begin
		int cycles;
		arst_n = 1'b0;
		for (int a = 0; a < 4096; a += 4) begin
			put_word(a, 32'hdead_0000 | a);
		end
		put_word(32'h300, LOAD_WORD);
		put_word(32'h000, i_type(12'h200, 5'd0, 3'b000, 5'd10, OPC_IMM)); // x10 = base.
		put_word(32'h004, i_type(12'h007, 5'd0, 3'b000, 5'd1, OPC_IMM));
		put_word(32'h008, i_type(12'hff4, 5'd1, 3'b000, 5'd2, OPC_IMM));
		put_word(32'h00c, r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3)); // sub.
		put_word(32'h010, r_type(7'h20, 5'd1, 5'd2, 3'b101, 5'd4)); // sra.
		put_word(32'h014, r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd5)); // sltu.
		put_word(32'h018, s_type(12'h000, 5'd3, 5'd10, SW));
		put_word(32'h01c, s_type(12'h004, 5'd4, 5'd10, SW));
		put_word(32'h020, s_type(12'h008, 5'd5, 5'd10, SW));
		put_word(32'h024, b_type(13'd12, 5'd1, 5'd1, 3'b000)); // beq taken.
		put_word(32'h028, s_type(12'h040, 5'd1, 5'd10, SW));
		put_word(32'h02c, s_type(12'h040, 5'd1, 5'd10, SW));
		put_word(32'h030, b_type(13'd12, 5'd1, 5'd2, 3'b100)); // blt taken.
		put_word(32'h034, s_type(12'h040, 5'd1, 5'd10, SW));
		put_word(32'h038, s_type(12'h040, 5'd1, 5'd10, SW));
		put_word(32'h03c, j_type(21'd12, 5'd6));
		put_word(32'h040, s_type(12'h040, 5'd1, 5'd10, SW));
		put_word(32'h044, s_type(12'h040, 5'd1, 5'd10, SW));
		put_word(32'h048, s_type(12'h00c, 5'd6, 5'd10, SW));
		put_word(32'h04c, i_type(12'h05c, 5'd0, 3'b000, 5'd7, OPC_IMM));
		put_word(32'h050, i_type(12'h000, 5'd7, 3'b000, 5'd8, OPC_JALR));
		put_word(32'h054, s_type(12'h040, 5'd1, 5'd10, SW));
		put_word(32'h058, s_type(12'h040, 5'd1, 5'd10, SW));
		put_word(32'h05c, s_type(12'h010, 5'd8, 5'd10, SW));
		put_word(32'h060, i_type(12'h100, 5'd10, 3'b010, 5'd9, OPC_LOAD));
		put_word(32'h064, i_type(12'h011, 5'd9, 3'b000, 5'd11, OPC_IMM)); // load use.
		put_word(32'h068, s_type(12'h014, 5'd11, 5'd10, SW));
		put_word(32'h06c, i_type(12'h0ab, 5'd0, 3'b000, 5'd12, OPC_IMM));
		put_word(32'h070, s_type(12'h102, 5'd12, 5'd10, SB));
		put_word(32'h074, i_type(12'h100, 5'd10, 3'b010, 5'd13, OPC_LOAD));
		put_word(32'h078, s_type(12'h018, 5'd13, 5'd10, SW));
		put_word(32'h07c, lui_word(20'hc0de0, 5'd14));
		put_word(32'h080, s_type(12'h1fc, 5'd14, 5'd10, SW)); // marker.
		put_word(32'h084, j_type(21'd0, 5'd0));

		// x1 is 7 and x2 is 7 - 12, so -5.
		expect_store(4'd0, "sub", BASE, 32'd12, FULL);
		expect_store(4'd1, "sra", BASE + 32'd4, 32'hffff_ffff, FULL); // sign bits only.
		expect_store(4'd2, "sltu", BASE + 32'd8, 32'd1, FULL); // -5 is huge unsigned.
		expect_store(4'd3, "jal_link", BASE + 32'd12, 32'h03c + 32'd4, FULL);
		expect_store(4'd4, "jalr_link", BASE + 32'd16, 32'h050 + 32'd4, FULL);
		expect_store(4'd5, "load_use", BASE + 32'd20, LOAD_WORD + 32'h11, FULL);
		// byte address 0x302 is lane 2 of word 0x300.
		expect_store(4'd6, "sb_lane", BASE + 32'h100, 32'h00ab_0000, 32'h00ff_0000);
		expect_store(4'd7, "sb_readback", BASE + 32'd24,
			(LOAD_WORD & ~32'h00ff_0000) | 32'h00ab_0000, FULL);
		expect_store(4'd8, "marker", BASE + 32'h1fc, 32'hc0de_0000, FULL);

		repeat (5) @(posedge clk);
		arst_n <= 1'b1;

		cycles = 0;
		while (store_idx != N_STORES && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles = cycles + 1;
		end
		if (store_idx == N_STORES) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			report_failure("timeout waiting for the marker store");
		end
	end

endmodule

//--- dv/tb_memory.sv
`timescale 1ns/1ps

module tb_memory (
	input  logic        clk,
	input  logic [31:0] memory_i_addr,
	output logic [31:0] memory_inst,
	input  logic [31:0] memory_d_addr,
	output logic [31:0] memory_rdata,
	input  logic        memory_wen,
	input  logic [31:0] memory_wmask,
	input  logic [31:0] memory_wdata,
	output logic        memory_ready
);

	localparam int WORDS = 1024;

	logic [31:0] mem [WORDS]; // 4 KiB, word indexed.

	assign memory_inst  = mem[memory_i_addr[11:2]];
	assign memory_rdata = mem[memory_d_addr[11:2]];

	// ############################################################
	// masked write, taken only on a ready edge
	// ############################################################
	always @(posedge clk) begin
		if (memory_wen && memory_ready) begin
			mem[memory_d_addr[11:2]] <= (mem[memory_d_addr[11:2]] & ~memory_wmask) |
				(memory_wdata & memory_wmask);
		end
	end

	// ready low on about a quarter of the cycles.
	initial begin
		memory_ready = 1'b0;
		void'($urandom(95));
		forever begin
			@(posedge clk);
			memory_ready <= ($urandom % 4) != 0;
		end
	end

endmodule

//--- logic/core_pipeline.sv
`timescale 1ns/1ps

module core_pipeline (
	input  logic        clk,
	input  logic        arst_n,
	output logic [31:0] memory_i_addr,
	input  logic [31:0] memory_inst,
	output logic [31:0] memory_d_addr,
	input  logic [31:0] memory_rdata,
	output logic        memory_wen,
	output logic [31:0] memory_wmask,
	output logic [31:0] memory_wdata,
	input  logic        memory_ready
);

	pipe_pkg::if_id_t  if_id;
	pipe_pkg::id_ex_t  id_ex;
	pipe_pkg::ex_mem_t ex_mem;
	pipe_pkg::wb_t     wb;
	logic              stall;
	logic              redirect;
	logic [31:0]       redirect_pc;
	logic [4:0]        rs1, rs2;
	logic [31:0]       rs1_data, rs2_data;

	fetch_stage i_fetch (
		.clk(clk), .arst_n(arst_n), .stall(stall),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.inst(memory_inst), .i_addr(memory_i_addr), .if_id(if_id)
	);

	reg_file i_reg_file (
		.clk(clk), .arst_n(arst_n), .rs1(rs1), .rs2(rs2),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .wb(wb)
	);

	decode_stage i_decode (
		.clk(clk), .arst_n(arst_n), .stall(stall), .flush(redirect),
		.if_id(if_id), .rs1(rs1), .rs2(rs2),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .id_ex(id_ex)
	);

	execute_stage i_execute (
		.clk(clk), .arst_n(arst_n), .stall(stall), .id_ex(id_ex), .wb(wb),
		.redirect(redirect), .redirect_pc(redirect_pc), .ex_mem(ex_mem)
	);

	mem_wb_stage i_mem_wb (
		.ex_mem(ex_mem), .d_addr(memory_d_addr), .wdata(memory_wdata),
		.wmask(memory_wmask), .wen(memory_wen), .rdata(memory_rdata),
		.ready(memory_ready), .stall(stall), .wb(wb)
	);

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             stall,
	input  logic             flush,
	input  pipe_pkg::if_id_t if_id,
	output logic [4:0]       rs1,
	output logic [4:0]       rs2,
	input  logic [31:0]      rs1_data,
	input  logic [31:0]      rs2_data,
	output pipe_pkg::id_ex_t id_ex
);

	rv_isa_pkg::opcode_e opcode;
	logic [2:0]          funct3;
	logic [4:0]          rd;
	logic                alt;
	logic                illegal;
	logic [31:0]         imm_i, imm_s, imm_b, imm_u, imm_j;
	pipe_pkg::id_ex_t    dec;

	function automatic pipe_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic sel);
		case (f3)
			rv_isa_pkg::F3_ADD_SUB: return sel ? pipe_pkg::SUB : pipe_pkg::ADD;
			rv_isa_pkg::F3_SLL:     return pipe_pkg::SLL;
			rv_isa_pkg::F3_SLT:     return pipe_pkg::SLT;
			rv_isa_pkg::F3_SLTU:    return pipe_pkg::SLTU;
			rv_isa_pkg::F3_XOR:     return pipe_pkg::XOR;
			rv_isa_pkg::F3_SRL_SRA: return sel ? pipe_pkg::SRA : pipe_pkg::SRL;
			rv_isa_pkg::F3_OR:      return pipe_pkg::OR;
			default:                return pipe_pkg::AND;
		endcase
	endfunction

	assign opcode = rv_isa_pkg::opcode_e'(if_id.inst[6:0]);
	assign rd     = if_id.inst[11:7];
	assign funct3 = if_id.inst[14:12];
	assign rs1    = if_id.inst[19:15];
	assign rs2    = if_id.inst[24:20];
	assign alt    = if_id.inst[rv_isa_pkg::FUNCT7_ALT_BIT];

	assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
	assign imm_s = {{20{if_id.inst[31]}}, if_id.inst[31:25], if_id.inst[11:7]};
	assign imm_b = {{19{if_id.inst[31]}}, if_id.inst[31], if_id.inst[7],
		if_id.inst[30:25], if_id.inst[11:8], 1'b0};
	assign imm_u = {if_id.inst[31:12], 12'b0};
	assign imm_j = {{11{if_id.inst[31]}}, if_id.inst[31], if_id.inst[19:12],
		if_id.inst[20], if_id.inst[30:21], 1'b0};

	always_comb begin
		dec          = '0;
		illegal      = 1'b0;
		dec.valid    = if_id.valid;
		dec.pc       = if_id.pc;
		dec.rs1      = rs1;
		dec.rs2      = rs2;
		dec.rs1_data = rs1_data;
		dec.rs2_data = rs2_data;
		dec.rd       = rd;
		dec.imm      = imm_i;
		case (opcode)
			rv_isa_pkg::OP: begin
				dec.alu_op = alu_decode(funct3, alt);
				dec.rf_wen = 1'b1;
			end
			rv_isa_pkg::OP_IMM: begin
				// only the shift form uses the alt bit.
				dec.alu_op      = alu_decode(funct3, alt && funct3 == rv_isa_pkg::F3_SRL_SRA);
				dec.op2_sel_imm = 1'b1;
				dec.rf_wen      = 1'b1;
			end
			rv_isa_pkg::LUI: begin
				dec.imm         = imm_u;
				dec.alu_op      = pipe_pkg::COPY2;
				dec.op2_sel_imm = 1'b1;
				dec.rf_wen      = 1'b1;
			end
			rv_isa_pkg::AUIPC: begin
				dec.imm         = imm_u;
				dec.op1_sel_pc  = 1'b1;
				dec.op2_sel_imm = 1'b1;
				dec.rf_wen      = 1'b1;
			end
			rv_isa_pkg::JAL: begin
				dec.imm    = imm_j;
				dec.br_op  = pipe_pkg::JUMP;
				dec.rf_wen = 1'b1;
				dec.wb_sel = pipe_pkg::PC4;
			end
			rv_isa_pkg::JALR: begin
				dec.op2_sel_imm = 1'b1; // alu forms rs1 + imm.
				dec.br_op       = pipe_pkg::JUMP;
				dec.jalr        = 1'b1;
				dec.rf_wen      = 1'b1;
				dec.wb_sel      = pipe_pkg::PC4;
			end
			rv_isa_pkg::BRANCH: begin
				dec.imm = imm_b;
				case (funct3)
					rv_isa_pkg::F3_BEQ:  dec.br_op = pipe_pkg::EQ;
					rv_isa_pkg::F3_BNE:  dec.br_op = pipe_pkg::NE;
					rv_isa_pkg::F3_BLT:  dec.br_op = pipe_pkg::LT;
					rv_isa_pkg::F3_BGE:  dec.br_op = pipe_pkg::GE;
					rv_isa_pkg::F3_BLTU: dec.br_op = pipe_pkg::LTU;
					rv_isa_pkg::F3_BGEU: dec.br_op = pipe_pkg::GEU;
					default:             illegal = 1'b1;
				endcase
			end
			rv_isa_pkg::LOAD: begin
				dec.op2_sel_imm = 1'b1;
				dec.mem_ren     = 1'b1;
				dec.rf_wen      = 1'b1;
				dec.wb_sel      = pipe_pkg::MEM;
				illegal         = (funct3 != rv_isa_pkg::F3_LW); // lw only.
			end
			rv_isa_pkg::STORE: begin
				dec.imm         = imm_s;
				dec.op2_sel_imm = 1'b1;
				dec.mem_wen     = 1'b1;
				dec.byte_store  = (funct3 == rv_isa_pkg::F3_SB);
				illegal = (funct3 != rv_isa_pkg::F3_SB) && (funct3 != rv_isa_pkg::F3_SW);
			end
			default: illegal = 1'b1;
		endcase
		if (rd == '0) begin
			dec.rf_wen = 1'b0; // x0 stays zero.
		end
		if (illegal || !if_id.valid) begin
			dec.valid   = 1'b0;
			dec.br_op   = pipe_pkg::NONE;
			dec.jalr    = 1'b0;
			dec.mem_ren = 1'b0;
			dec.mem_wen = 1'b0;
			dec.rf_wen  = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_ex <= '0;
		end else if (!stall) begin
			id_ex <= flush ? '0 : dec; // flush leaves a bubble.
		end
	end

	a_mem_excl: assert property (@(posedge clk) disable iff (!arst_n)
		id_ex.valid |-> !(id_ex.mem_ren && id_ex.mem_wen))
		else $error("decode entry both loads and stores");

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              stall,
	input  pipe_pkg::id_ex_t  id_ex,
	input  pipe_pkg::wb_t     wb,
	output logic              redirect,
	output logic [31:0]       redirect_pc,
	output pipe_pkg::ex_mem_t ex_mem
);

	logic              fwd1, fwd2;
	logic              taken;
	logic [31:0]       src1, src2;
	logic [31:0]       op1, op2;
	logic [31:0]       alu_result;
	pipe_pkg::ex_mem_t nxt;

	// ############################################################
	// operand forwarding from writeback
	// ############################################################
	assign fwd1 = wb.rf_wen && wb.rd != '0 && wb.rd == id_ex.rs1;
	assign fwd2 = wb.rf_wen && wb.rd != '0 && wb.rd == id_ex.rs2;
	assign src1 = fwd1 ? wb.data : id_ex.rs1_data;
	assign src2 = fwd2 ? wb.data : id_ex.rs2_data;
	assign op1  = id_ex.op1_sel_pc ? id_ex.pc : src1;
	assign op2  = id_ex.op2_sel_imm ? id_ex.imm : src2;

	always_comb begin
		case (id_ex.alu_op)
			pipe_pkg::SUB:   alu_result = op1 - op2;
			pipe_pkg::SLL:   alu_result = op1 << op2[4:0];
			pipe_pkg::SLT:   alu_result = {31'b0, $signed(op1) < $signed(op2)};
			pipe_pkg::SLTU:  alu_result = {31'b0, op1 < op2};
			pipe_pkg::XOR:   alu_result = op1 ^ op2;
			pipe_pkg::SRL:   alu_result = op1 >> op2[4:0];
			pipe_pkg::SRA:   alu_result = $unsigned($signed(op1) >>> op2[4:0]);
			pipe_pkg::OR:    alu_result = op1 | op2;
			pipe_pkg::AND:   alu_result = op1 & op2;
			pipe_pkg::COPY2: alu_result = op2;
			default:         alu_result = op1 + op2;
		endcase
	end

	always_comb begin
		case (id_ex.br_op)
			pipe_pkg::EQ:   taken = (src1 == src2);
			pipe_pkg::NE:   taken = (src1 != src2);
			pipe_pkg::LT:   taken = ($signed(src1) < $signed(src2));
			pipe_pkg::GE:   taken = ($signed(src1) >= $signed(src2));
			pipe_pkg::LTU:  taken = (src1 < src2);
			pipe_pkg::GEU:  taken = (src1 >= src2);
			pipe_pkg::JUMP: taken = 1'b1;
			default:        taken = 1'b0;
		endcase
	end

	assign redirect    = id_ex.valid && taken && !stall; // held until memory is ready.
	assign redirect_pc = id_ex.jalr ? {alu_result[31:1], 1'b0} : id_ex.pc + id_ex.imm;

	always_comb begin
		nxt            = '0;
		nxt.valid      = id_ex.valid;
		nxt.pc4        = id_ex.pc + 32'd4;
		nxt.alu_result = alu_result;
		nxt.store_data = src2;
		nxt.mem_ren    = id_ex.valid && id_ex.mem_ren;
		nxt.mem_wen    = id_ex.valid && id_ex.mem_wen;
		nxt.byte_store = id_ex.byte_store;
		nxt.rf_wen     = id_ex.valid && id_ex.rf_wen;
		nxt.rd         = id_ex.rd;
		nxt.wb_sel     = id_ex.wb_sel;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem <= '0;
		end else if (!stall) begin
			ex_mem <= nxt;
		end
	end

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             stall,
	input  logic             redirect,
	input  logic [31:0]      redirect_pc,
	input  logic [31:0]      inst,
	output logic [31:0]      i_addr,
	output pipe_pkg::if_id_t if_id
);

	logic [31:0] pc;

	assign i_addr = pc; // instruction port answers in the same cycle.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= rv_isa_pkg::RESET_PC;
		end else if (!stall) begin
			pc <= redirect ? redirect_pc : pc + 32'd4;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_id.valid <= 1'b0;
			if_id.pc    <= rv_isa_pkg::RESET_PC;
			if_id.inst  <= rv_isa_pkg::NOP_INST;
		end else if (!stall) begin
			if (redirect) begin
				if_id.valid <= 1'b0; // wrong-path word dropped.
				if_id.pc    <= pc;
				if_id.inst  <= rv_isa_pkg::NOP_INST;
			end else begin
				if_id.valid <= 1'b1;
				if_id.pc    <= pc;
				if_id.inst  <= inst;
			end
		end
	end

endmodule

//--- logic/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
	input  pipe_pkg::ex_mem_t ex_mem,
	output logic [31:0]       d_addr,
	output logic [31:0]       wdata,
	output logic [31:0]       wmask,
	output logic              wen,
	input  logic [31:0]       rdata,
	input  logic              ready,
	output logic              stall,
	output pipe_pkg::wb_t     wb
);

	logic [1:0] lane;
	logic       access;

	assign lane   = ex_mem.alu_result[1:0];
	assign access = ex_mem.valid && (ex_mem.mem_ren || ex_mem.mem_wen);

	// ############################################################
	// data port
	// ############################################################
	assign d_addr = {ex_mem.alu_result[31:2], 2'b00};
	assign wmask  = ex_mem.byte_store ? (32'h0000_00ff << {lane, 3'b000}) : 32'hffff_ffff;
	assign wdata  = ex_mem.byte_store ? {4{ex_mem.store_data[7:0]}} : ex_mem.store_data;
	assign wen    = ex_mem.valid && ex_mem.mem_wen; // held high while stalled.
	assign stall  = access && !ready;

	// ############################################################
	// writeback select
	// ############################################################
	always_comb begin
		wb.rf_wen = ex_mem.valid && ex_mem.rf_wen && !stall;
		wb.rd     = ex_mem.rd;
		case (ex_mem.wb_sel)
			pipe_pkg::MEM: wb.data = rdata;
			pipe_pkg::PC4: wb.data = ex_mem.pc4;
			default:       wb.data = ex_mem.alu_result;
		endcase
	end

	// word accesses sit on a word boundary.
	always_comb begin
		if (access && !ex_mem.byte_store) begin
			assert (lane == 2'b00)
				else $error("misaligned word access at %h", ex_mem.alu_result);
		end
	end

endmodule

//--- logic/pipe_pkg.sv
package pipe_pkg;

	typedef enum logic [3:0] {
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, COPY2
	} alu_op_e;

	typedef enum logic [2:0] {
		NONE, EQ, NE, LT, GE, LTU, GEU, JUMP
	} br_op_e;

	typedef enum logic [1:0] {
		ALU, MEM, PC4
	} wb_sel_e;

	// ############################################################
	// stage registers
	// ############################################################
	typedef struct packed {
		logic                          valid;
		logic [rv_isa_pkg::XLEN-1:0]   pc;
		logic [rv_isa_pkg::XLEN-1:0]   inst;
	} if_id_t;

	typedef struct packed {
		logic                              valid;
		logic [rv_isa_pkg::XLEN-1:0]       pc;
		logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1;
		logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2;
		logic [rv_isa_pkg::XLEN-1:0]       rs1_data;
		logic [rv_isa_pkg::XLEN-1:0]       rs2_data;
		logic [rv_isa_pkg::XLEN-1:0]       imm;
		alu_op_e                           alu_op;
		logic                              op1_sel_pc;
		logic                              op2_sel_imm;
		br_op_e                            br_op;
		logic                              jalr;
		logic                              mem_ren;
		logic                              mem_wen;
		logic                              byte_store;
		logic                              rf_wen;
		logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
		wb_sel_e                           wb_sel;
	} id_ex_t;

	typedef struct packed {
		logic                              valid;
		logic [rv_isa_pkg::XLEN-1:0]       pc4;
		logic [rv_isa_pkg::XLEN-1:0]       alu_result;
		logic [rv_isa_pkg::XLEN-1:0]       store_data;
		logic                              mem_ren;
		logic                              mem_wen;
		logic                              byte_store;
		logic                              rf_wen;
		logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
		wb_sel_e                           wb_sel;
	} ex_mem_t;

	typedef struct packed {
		logic                              rf_wen;
		logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
		logic [rv_isa_pkg::XLEN-1:0]       data;
	} wb_t; // also the forwarding record.

endpackage

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic          clk,
	input  logic          arst_n,
	input  logic [4:0]    rs1,
	input  logic [4:0]    rs2,
	output logic [31:0]   rs1_data,
	output logic [31:0]   rs2_data,
	input  pipe_pkg::wb_t wb
);

	logic [31:0] regs [rv_isa_pkg::REG_COUNT];

	always_ff @(posedge clk) begin
		if (wb.rf_wen && wb.rd != '0) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// write-through so decode sees this cycle's writeback.
	assign rs1_data = (rs1 == '0) ? '0 :
		(wb.rf_wen && wb.rd == rs1) ? wb.data : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 :
		(wb.rf_wen && wb.rd == rs2) ? wb.data : regs[rs2];

	a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n)
		(wb.rf_wen && wb.rd == '0) |-> (wb.data == '0))
		else $error("x0 written with nonzero data %h", wb.data);

endmodule

//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

	// ############################################################
	// widths and reset values
	// ############################################################
	localparam int XLEN = 32;
	localparam int REG_COUNT = 32;
	localparam int REG_ADDR_W = $clog2(REG_COUNT);
	localparam int OPCODE_W = 7;
	localparam int FUNCT3_W = 3;
	localparam int FUNCT7_ALT_BIT = 30; // picks sub and sra.

	localparam logic [XLEN-1:0] RESET_PC = '0;
	localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013; // addi x0, x0, 0.

	// ############################################################
	// major opcodes
	// ############################################################
	typedef enum logic [OPCODE_W-1:0] {
		OP     = 7'b011_0011,
		OP_IMM = 7'b001_0011,
		LUI    = 7'b011_0111,
		AUIPC  = 7'b001_0111,
		JAL    = 7'b110_1111,
		JALR   = 7'b110_0111,
		BRANCH = 7'b110_0011,
		LOAD   = 7'b000_0011,
		STORE  = 7'b010_0011
	} opcode_e;

	// ############################################################
	// funct3 fields
	// ############################################################
	localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_SLL     = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
	localparam logic [FUNCT3_W-1:0] F3_SLTU    = 3'b011;
	localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
	localparam logic [FUNCT3_W-1:0] F3_SRL_SRA = 3'b101;
	localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
	localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

	localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
	localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
	localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
	localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

	localparam logic [FUNCT3_W-1:0] F3_SB = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_SW = 3'b010;
	localparam logic [FUNCT3_W-1:0] F3_LW = 3'b010;

endpackage

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_core_pipeline -f core_pipe.f -o sim_core_pipe &&
./obj_dir/sim_core_pipe || exit 1
